// File: cache/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl #(
  parameter int REFILL_WORDS = 2
) (
  input  logic                  CPU_CLK,
  input  logic                  RST,
  input  cache_pkg::cpu_req_t   req,
  input  logic                  tlb_we,
  input  logic                  hit,
  input  logic                  fault,
  input  logic                  last_word,
  input  logic                  dma_grant,
  input  logic                  mem_ack,
  output cache_pkg::ctrl_state_e state,
  output logic                  busy_n,
  output logic                  tlb_busy,
  output logic                  mem_active,
  output logic                  refill_start,
  output logic                  refill_step,
  output logic                  array_we,
  output logic                  fill_sel
);

  cache_pkg::ctrl_state_e next_state;
  logic                   mem_phase;
  logic                   ack_ok;
  logic                   write_done;

  // ------------------------------
  // memory handshake
  // ------------------------------

  assign mem_phase  = (state == cache_pkg::REFILL) || (state == cache_pkg::WRITE_MEM);
  // no request goes out without the dma grant
  assign mem_active = mem_phase && dma_grant;
  assign ack_ok     = mem_active && mem_ack;

  // ------------------------------
  // next state and enables
  // ------------------------------

  always_comb
  begin
    next_state   = state;
    busy_n       = 1'b0;
    tlb_busy     = 1'b0;
    refill_start = 1'b0;
    refill_step  = 1'b0;
    array_we     = 1'b0;
    fill_sel     = 1'b0;
    case (state)
      cache_pkg::IDLE:
      begin
        busy_n = 1'b1;
        if (tlb_we)
        begin
          // cpu holds the read while the slot is rewritten
          busy_n     = 1'b0;
          next_state = cache_pkg::TLB_WRITE;
        end
        else if (fault)
        begin
          // access dropped, nothing else happens
          busy_n = 1'b1;
        end
        else if (req.we)
        begin
          // completion cycle of the previous write-through
          if (!write_done)
          begin
            busy_n     = 1'b0;
            next_state = cache_pkg::WRITE_MEM;
          end
        end
        else if (!hit)
        begin
          busy_n       = 1'b0;
          refill_start = 1'b1;
          next_state   = cache_pkg::REFILL;
        end
      end
      cache_pkg::REFILL:
      begin
        fill_sel = 1'b1;
        if (ack_ok)
        begin
          array_we    = 1'b1;
          refill_step = 1'b1;
          if (last_word)
            next_state = cache_pkg::REREAD;
        end
      end
      cache_pkg::REREAD:
      begin
        next_state = cache_pkg::IDLE;
      end
      cache_pkg::WRITE_MEM:
      begin
        if (ack_ok)
        begin
          // no write-allocate, only a hit touches the array
          array_we   = hit;
          next_state = cache_pkg::IDLE;
        end
      end
      cache_pkg::TLB_WRITE:
      begin
        tlb_busy   = 1'b1;
        next_state = cache_pkg::IDLE;
      end
      default:
      begin
        next_state = cache_pkg::IDLE;
      end
    endcase
  end

  // ------------------------------
  // state registers
  // ------------------------------

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= cache_pkg::IDLE;
      write_done <= 1'b0;
    end
    else
    begin
      state      <= next_state;
      write_done <= (state == cache_pkg::WRITE_MEM) && ack_ok;
    end
  end

endmodule

// File: cache/cache_store.sv
`timescale 1ns/10ps

module cache_store #(
  parameter int OFF_W = 1
) (
  input  logic                          CPU_CLK,
  input  logic                          RST,
  input  logic [cache_pkg::VADDR_W-1:0] precycle_addr,
  input  cache_pkg::cpu_req_t           req,
  input  logic [cache_pkg::PPN_W-1:0]   ppn,
  input  logic [OFF_W-1:0]              word_offset,
  input  logic                          array_we,
  input  logic                          fill_sel,
  input  logic [31:0]                   mem_rdata,
  output logic [31:0]                   rdata,
  output logic                          hit
);

  localparam int DEPTH = 2 ** cache_pkg::IDX_W;

  logic [31:0]                  data_mem [DEPTH];
  logic [cache_pkg::CTAG_W-1:0] tag_mem  [DEPTH];
  logic [DEPTH-1:0]             valid;

  logic [cache_pkg::IDX_W-1:0]  rd_idx;
  logic [cache_pkg::IDX_W-1:0]  wr_idx;
  logic [31:0]                  wr_data;
  logic [cache_pkg::CTAG_W-1:0] cur_tag;

  logic [31:0]                  data_q;
  logic [cache_pkg::CTAG_W-1:0] tag_q;
  logic                         valid_q;

  // ------------------------------
  // index and write source
  // ------------------------------

  // read one cycle ahead so the word lines up with the cycle address
  assign rd_idx  = precycle_addr[9:2];
  // a fill walks the line base, otherwise the word itself
  assign wr_idx  = fill_sel ? {req.addr[9:2+OFF_W], word_offset} : req.addr[9:2];
  assign wr_data = fill_sel ? mem_rdata : req.wdata;
  // physical page joined with address bits 17:10
  assign cur_tag = {ppn, req.addr[17:10]};

  // ------------------------------
  // arrays
  // ------------------------------

  always_ff @(posedge CPU_CLK)
  begin
    if (array_we)
    begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= cur_tag;
    end
    data_q <= data_mem[rd_idx];
    tag_q  <= tag_mem[rd_idx];
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (array_we)
        valid[wr_idx] <= 1'b1;
      valid_q <= valid[rd_idx];
    end
  end

  assign hit   = valid_q && (tag_q == cur_tag);
  assign rdata = data_q;

endmodule

// File: cache/refill_counter.sv
`timescale 1ns/10ps

module refill_counter #(
  parameter int REFILL_WORDS = 2
) (
  input  logic                            CPU_CLK,
  input  logic                            RST,
  input  logic                            start,
  input  logic                            step,
  output logic [$clog2(REFILL_WORDS)-1:0] word_offset,
  output logic                            last_word
);

  localparam int OFF_W = $clog2(REFILL_WORDS);
  localparam logic [OFF_W-1:0] TOP = OFF_W'(REFILL_WORDS - 1);

  logic [OFF_W-1:0] offset;

  // ------------------------------
  // word offset within the line
  // ------------------------------

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      offset <= '0;
    end
    else if (start)
    begin
      offset <= '0;
    end
    else if (step)
    begin
      // wraps back to zero after the last word
      offset <= offset + 1'b1;
    end
  end

  assign word_offset = offset;

  // top count reached, the next ack closes the line
  assign last_word = (offset == TOP);

endmodule

// File: cache/tlb_store.sv
`timescale 1ns/10ps

module tlb_store (
  input  logic                          CPU_CLK,
  input  logic                          RST,
  input  logic [cache_pkg::VADDR_W-1:0] precycle_addr,
  input  cache_pkg::cpu_req_t           req,
  input  logic                          vmem_act,
  input  logic                          tlb_we,
  input  logic [cache_pkg::VADDR_W-1:0] tlb_addr,
  output logic [cache_pkg::PPN_W-1:0]   ppn,
  output logic                          fault
);

  localparam int DEPTH = 2 ** cache_pkg::IDX_W;

  cache_pkg::tlb_entry_t              tlb_mem [DEPTH];
  logic [DEPTH-1:0]                   slot_valid;

  cache_pkg::tlb_entry_t              new_entry;
  cache_pkg::tlb_entry_t              entry_q;
  logic                               valid_q;
  logic [cache_pkg::VTAG_W-1:0]       req_vtag;

  // ------------------------------
  // slot write
  // ------------------------------

  // entry comes in on the cpu data bus
  always_comb
  begin
    new_entry.ppn  = req.wdata[29:16];
    new_entry.vtag = req.wdata[13:0];
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (tlb_we)
      tlb_mem[tlb_addr[9:2]] <= new_entry;
    entry_q <= tlb_mem[precycle_addr[17:10]];
  end

  // empty slots never translate
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      slot_valid <= '0;
      valid_q    <= 1'b0;
    end
    else
    begin
      if (tlb_we)
        slot_valid[tlb_addr[9:2]] <= 1'b1;
      valid_q <= slot_valid[precycle_addr[17:10]];
    end
  end

  // ------------------------------
  // translation
  // ------------------------------

  assign req_vtag = req.addr[31:18];

  // bypass passes the page bits through untouched
  assign ppn   = vmem_act ? entry_q.ppn : req_vtag;
  assign fault = vmem_act && (!valid_q || (entry_q.vtag != req_vtag));

endmodule

// File: common/cache_pkg.sv
package cache_pkg;

  // ------------------------------
  // address fields
  // ------------------------------

  // cpu virtual address, byte granular
  localparam int VADDR_W = 32;
  // physical page number out of the tlb
  localparam int PPN_W   = 14;
  // virtual page tag, address bits 31:18
  localparam int VTAG_W  = 14;
  // index into the cache, tag and tlb arrays
  localparam int IDX_W   = 8;
  // cache tag is physical address bits 31:10
  localparam int CTAG_W  = PPN_W + IDX_W;

  // ------------------------------
  // bundles
  // ------------------------------

  // one tlb slot, loaded from cpu write data
  // bits 29:16 carry the page, bits 13:0 the virtual tag
  typedef struct packed {
    logic [PPN_W-1:0]  ppn;
    logic [VTAG_W-1:0] vtag;
  } tlb_entry_t;

  // cpu access as seen in the cycle phase
  typedef struct packed {
    logic [VADDR_W-1:0] addr;
    logic [31:0]        wdata;
    logic               we;
  } cpu_req_t;

  // memory side request, word addressed
  // held stable until the ack is sampled
  typedef struct packed {
    logic [VADDR_W-3:0] addr;
    logic [31:0]        wdata;
    logic               we;
    logic               active;
  } mem_req_t;

  // ------------------------------
  // controller
  // ------------------------------

  // IDLE       hits, faults and new accesses
  // REFILL     line fill from memory, one word per ack
  // REREAD     one cycle for the arrays to read the new line
  // WRITE_MEM  write-through, waits for the single ack
  // TLB_WRITE  slot written, tlb re-read at the held address
  typedef enum logic [2:0] {
    IDLE,
    REFILL,
    REREAD,
    WRITE_MEM,
    TLB_WRITE
  } ctrl_state_e;

endpackage

// File: rtl/cache_top.sv
`timescale 1ns/10ps

module cache_top #(
  parameter int REFILL_WORDS = 2
) (
  input  logic                          CPU_CLK,
  input  logic                          RST,
  input  logic [cache_pkg::VADDR_W-1:0] precycle_addr,
  input  cache_pkg::cpu_req_t           req,
  input  logic                          vmem_act,
  input  logic                          tlb_we,
  input  logic [cache_pkg::VADDR_W-1:0] tlb_addr,
  input  logic                          dma_grant,
  input  logic                          mem_ack,
  input  logic [31:0]                   mem_rdata,
  output logic [31:0]                   rdata,
  output logic                          busy_n,
  output logic                          tlb_busy,
  output logic                          fault,
  output cache_pkg::mem_req_t           mem_req
);

  localparam int OFF_W = $clog2(REFILL_WORDS);

  cache_pkg::ctrl_state_e        state;
  logic [cache_pkg::PPN_W-1:0]   ppn;
  logic [OFF_W-1:0]              word_offset;
  logic                          hit;
  logic                          last_word;
  logic                          mem_active;
  logic                          refill_start;
  logic                          refill_step;
  logic                          array_we;
  logic                          fill_sel;

  // ------------------------------
  // blocks
  // ------------------------------

  cache_ctrl #(
    .REFILL_WORDS (REFILL_WORDS)
  ) ctrl_i (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .req          (req),
    .tlb_we       (tlb_we),
    .hit          (hit),
    .fault        (fault),
    .last_word    (last_word),
    .dma_grant    (dma_grant),
    .mem_ack      (mem_ack),
    .state        (state),
    .busy_n       (busy_n),
    .tlb_busy     (tlb_busy),
    .mem_active   (mem_active),
    .refill_start (refill_start),
    .refill_step  (refill_step),
    .array_we     (array_we),
    .fill_sel     (fill_sel)
  );

  refill_counter #(
    .REFILL_WORDS (REFILL_WORDS)
  ) counter_i (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .start       (refill_start),
    .step        (refill_step),
    .word_offset (word_offset),
    .last_word   (last_word)
  );

  cache_store #(
    .OFF_W (OFF_W)
  ) store_i (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .precycle_addr (precycle_addr),
    .req           (req),
    .ppn           (ppn),
    .word_offset   (word_offset),
    .array_we      (array_we),
    .fill_sel      (fill_sel),
    .mem_rdata     (mem_rdata),
    .rdata         (rdata),
    .hit           (hit)
  );

  tlb_store tlb_i (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .precycle_addr (precycle_addr),
    .req           (req),
    .vmem_act      (vmem_act),
    .tlb_we        (tlb_we),
    .tlb_addr      (tlb_addr),
    .ppn           (ppn),
    .fault         (fault)
  );

  // ------------------------------
  // memory request
  // ------------------------------

  always_comb
  begin
    // refill words come from the aligned line, writes use the word itself
    if (state == cache_pkg::REFILL)
      mem_req.addr = {ppn, req.addr[17:2+OFF_W], word_offset};
    else
      mem_req.addr = {ppn, req.addr[17:2]};
    mem_req.wdata  = req.wdata;
    mem_req.we     = (state == cache_pkg::WRITE_MEM);
    mem_req.active = mem_active;
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_cache -o sim_tb_cache
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF "** PASS **"; then
  exit 0
fi
exit 1

// File: src.f
common/cache_pkg.sv
cache/cache_ctrl.sv
cache/refill_counter.sv
cache/cache_store.sv
cache/tlb_store.sv
rtl/cache_top.sv
test/tb_cache.sv

// File: test/cache_stimulus.txt
// op (0 tlb write, 1 read, 2 write, F end)  addr  data  vmem_act
// expected rdata  expected fault  expected physical word address (FFFFFFFF hit or none)
0 00000014 01230002 1 00000000 0 FFFFFFFF
1 00081420 00000000 1 5B79A0AD 0 01230508
1 00081420 00000000 1 5B79A0AD 0 FFFFFFFF
1 00081424 00000000 1 5B79A0AC 0 FFFFFFFF
2 00081424 CAFEF00D 1 00000000 0 01230509
1 00081424 00000000 1 CAFEF00D 0 FFFFFFFF
// virtual tag mismatch
1 000C1420 00000000 1 00000000 1 FFFFFFFF
// translation off
1 00081420 00000000 0 5A58A0AD 0 00020508
1 00081420 00000000 0 5A58A0AD 0 FFFFFFFF
1 12345678 00000000 0 5ED7B03B 0 048D159E
2 12345678 0BADBEEF 0 00000000 0 048D159E
1 12345678 00000000 0 0BADBEEF 0 FFFFFFFF
// write miss, no allocate
2 00081428 11223344 1 00000000 0 0123050A
1 00081428 00000000 1 11223344 0 0123050A
0 000000F0 2ABC1F00 1 00000000 0 FFFFFFFF
1 7C00F010 00000000 1 70E699A1 0 2ABC3C04
1 7C00F014 00000000 1 70E699A0 0 FFFFFFFF
1 7C04F010 00000000 1 00000000 1 FFFFFFFF
F 00000000 00000000 0 00000000 0 00000000

// File: test/tb_cache.sv
`timescale 1ns/10ps

module tb_cache;

  localparam int          REFILL_WORDS = 2;
  localparam int          FIELDS       = 7;
  localparam int          MAX_OPS      = 64;
  localparam logic [31:0] IDLE_ADDR    = 32'hFFFF_FC00;
  localparam logic [31:0] PATTERN      = 32'h5A5A_A5A5;
  localparam logic [31:0] NO_ADDR      = 32'hFFFF_FFFF;

  logic                   CPU_CLK;
  logic                   RST;
  logic [31:0]            precycle_addr;
  cache_pkg::cpu_req_t    req;
  logic                   vmem_act;
  logic                   tlb_we;
  logic [31:0]            tlb_addr;
  logic                   dma_grant;
  logic                   mem_ack;
  logic [31:0]            mem_rdata;
  logic [31:0]            rdata;
  logic                   busy_n;
  logic                   tlb_busy;
  logic                   fault;
  cache_pkg::mem_req_t    mem_req;

  logic [31:0]            stim [FIELDS*MAX_OPS];
  logic [31:0]            mem_model [logic [29:0]];
  cache_pkg::mem_req_t    req_log [$];
  int                     seed = 79350;
  int                     value_errors = 0;
  int                     other_errors = 0;
  int                     cycles = 0;
  int                     cycle_limit = 0;

  cache_top #(
    .REFILL_WORDS (REFILL_WORDS)
  ) dut_i (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .precycle_addr (precycle_addr),
    .req           (req),
    .vmem_act      (vmem_act),
    .tlb_we        (tlb_we),
    .tlb_addr      (tlb_addr),
    .dma_grant     (dma_grant),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .rdata         (rdata),
    .busy_n        (busy_n),
    .tlb_busy      (tlb_busy),
    .fault         (fault),
    .mem_req       (mem_req)
  );

  initial
  begin
    CPU_CLK = 1'b0;
    forever #2 CPU_CLK = ~CPU_CLK;
  end

  // ------------------------------
  // memory model
  // ------------------------------

  // acks land 1 ns after the edge and are sampled at the next edge
  initial
  begin
    int lat;
    lat       = 0;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever
    begin
      @(posedge CPU_CLK);
      #1;
      if (mem_ack)
        mem_ack = 1'b0;
      else if (mem_req.active)
      begin
        if (lat == 0)
          lat = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
        lat = lat - 1;
        if (lat == 0)
        begin
          if (mem_req.we)
            mem_model[mem_req.addr] = mem_req.wdata;
          else if (mem_model.exists(mem_req.addr))
            mem_rdata = mem_model[mem_req.addr];
          else
            mem_rdata = {2'b00, mem_req.addr} ^ PATTERN;
          req_log.push_back(mem_req);
          mem_ack = 1'b1;
        end
      end
    end
  end

  // hang guard
  always @(posedge CPU_CLK)
  begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("run hung after %0d cycles in state %s", cycles, dut_i.state.name());
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      value_errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_mem_req(input string name, input cache_pkg::mem_req_t exp,
                               input cache_pkg::mem_req_t act);
    if (act !== exp)
    begin
      value_errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_fault(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      value_errors++;
      $display("FAIL %s fault expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      value_errors++;
      $display("FAIL %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input cache_pkg::ctrl_state_e exp,
                             input cache_pkg::ctrl_state_e act);
    if (act !== exp)
    begin
      value_errors++;
      $display("FAIL %s state expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  // ------------------------------
  // drivers
  // ------------------------------

  task automatic next_cycle();
    @(posedge CPU_CLK);
    #1;
  endtask

  // idle address hits an empty tlb slot, so idle cycles fault and do nothing
  task automatic go_idle();
    precycle_addr = IDLE_ADDR;
    req.addr      = IDLE_ADDR;
    req.wdata     = '0;
    req.we        = 1'b0;
    vmem_act      = 1'b1;
  endtask

  task automatic check_requests(input string name, input logic [31:0] op,
                                input logic [31:0] data, input logic exp_fault,
                                input logic [31:0] exp_waddr);
    cache_pkg::mem_req_t exp;
    int                  n;
    n = 0;
    if (op == 32'd2)
      n = 1;
    else if (!exp_fault && exp_waddr != NO_ADDR)
      n = REFILL_WORDS;
    if (req_log.size() != n)
    begin
      other_errors++;
      $display("%s made %0d memory requests where %0d were due", name, req_log.size(), n);
    end
    else
    begin
      for (int i = 0; i < n; i++)
      begin
        exp.wdata  = data;
        exp.we     = (op == 32'd2);
        exp.active = 1'b1;
        if (op == 32'd2)
          exp.addr = exp_waddr[29:0];
        else
          exp.addr = (exp_waddr[29:0] & ~30'(REFILL_WORDS - 1)) + 30'(i);
        check_mem_req(name, exp, req_log[i]);
      end
    end
  endtask

  task automatic run_tlb_write(input string name, input logic [31:0] addr,
                               input logic [31:0] data);
    next_cycle();
    tlb_addr  = addr;
    req.wdata = data;
    tlb_we    = 1'b1;
    next_cycle();
    tlb_we    = 1'b0;
    req.wdata = '0;
    #2;
    check_flag({name, " tlb_busy"}, 1'b1, tlb_busy);
    while (!busy_n)
    begin
      next_cycle();
      #2;
    end
    check_flag({name, " tlb_busy after"}, 1'b0, tlb_busy);
  endtask

  task automatic run_access(input string name, input logic [31:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input logic vmem,
                            input logic [31:0] exp_rdata, input logic exp_fault,
                            input logic [31:0] exp_waddr);
    next_cycle();
    precycle_addr = addr;
    next_cycle();
    req.addr  = addr;
    req.wdata = data;
    req.we    = (op == 32'd2);
    vmem_act  = vmem;
    req_log.delete();
    #2;
    check_fault(name, exp_fault, fault);
    while (!busy_n)
    begin
      next_cycle();
      #2;
    end
    if (op == 32'd1 && !exp_fault)
      check_word(name, exp_rdata, rdata);
    next_cycle();
    go_idle();
    #2;
    check_state(name, cache_pkg::IDLE, dut_i.state);
    check_requests(name, op, data, exp_fault, exp_waddr);
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  initial
  begin
    int    n_ops;
    int    b;
    string name;
    n_ops         = 0;
    RST           = 1'b0;
    tlb_we        = 1'b0;
    tlb_addr      = '0;
    dma_grant     = 1'b1;
    precycle_addr = IDLE_ADDR;
    req.addr      = IDLE_ADDR;
    req.wdata     = '0;
    req.we        = 1'b0;
    vmem_act      = 1'b1;
    $readmemh("test/cache_stimulus.txt", stim);
    while (n_ops < MAX_OPS && stim[n_ops*FIELDS] != 32'hF)
      n_ops++;
    cycle_limit = 20 * n_ops;

    repeat (2) @(posedge CPU_CLK);
    #1;
    RST = 1'b1;
    #2;
    check_flag("reset busy_n", 1'b1, busy_n);
    check_flag("reset tlb_busy", 1'b0, tlb_busy);
    check_flag("reset mem active", 1'b0, mem_req.active);
    check_state("reset", cache_pkg::IDLE, dut_i.state);

    for (int i = 0; i < n_ops; i++)
    begin
      b = i * FIELDS;
      $sformat(name, "op%0d", i);
      if (stim[b] == 32'd0)
        run_tlb_write(name, stim[b+1], stim[b+2]);
      else
        run_access(name, stim[b], stim[b+1], stim[b+2], stim[b+3][0],
                   stim[b+4], stim[b+5][0], stim[b+6]);
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
